/* compile.f */
+incdir+include
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_stage.sv
sim/ex_stage_checker.sv
sim/tb_ex_stage.sv

/* include/ex_defines.svh */
/*
  Shared width and timing macros for the execute stage
  Data width, register address width, high-half multiply step count
*/

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

////////////////////
// Datapath widths
////////////////////

// RV32 integer data width
`define EX_XLEN 32

// Register file address width, x0 to x31
`define EX_RF_ADDR_W 5

////////////////////
// Multiplier timing
////////////////////

// One 16x16 partial product per cycle, four halves combinations
`define EX_MULH_STEPS 4

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it and scan the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_ex_stage \
  -o tb_ex_stage \
  && ./obj_dir/tb_ex_stage 2>&1 | tee "$LOG" \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "Test failed" "$LOG" && { echo "Failure reported in $LOG"; exit 1; }
echo "No failure reported in $LOG"
exit 0

/* sim/ex_stage_checker.sv */
/*
  Assertion module bound to the execute stage
  Reset values, stall rules, EX/WB register hold, multiplier step bound
*/

`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage_checker
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ex_valid_i,
  input  logic                      wb_ready_i,
  input  logic                      mult_en_i,
  input  ex_pkg::mult_op_e          mult_op_i,
  input  ex_pkg::mult_state_e       mult_state_i,
  input  logic                      wb_rf_we_i,
  input  logic [`EX_RF_ADDR_W-1:0]  wb_rf_waddr_i,
  input  logic [`EX_XLEN-1:0]       wb_rf_wdata_i,
  input  logic                      wb_wdata_ex_en_i
);

  // Consecutive cycles spent in STEP
  logic [2:0] step_run;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      step_run <= '0;
    end
    else if (mult_state_i == ex_pkg::STEP)
    begin
      step_run <= step_run + 3'd1;
    end
    else
    begin
      step_run <= '0;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // Register has seen at least one edge under reset
  reset_values: assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |->
    (!wb_rf_we_i && !wb_wdata_ex_en_i && wb_rf_waddr_i == '0 && wb_rf_wdata_i == '0))
    else $error("EX/WB register not cleared by reset");

  // High-half product is handed on only once the accumulator is complete
  valid_needs_mult: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_i && mult_en_i && mult_op_i != ex_pkg::MUL) |->
    (mult_state_i == ex_pkg::DONE))
    else $error("High-half product passed on before the multiplier reached DONE");

  we_rise_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_rf_we_i) |-> $past(ex_valid_i))
    else $error("wb_rf_we_o rose without a valid instruction");

  // Write-back stall freezes the whole register
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable({wb_rf_we_i, wb_rf_waddr_i, wb_rf_wdata_i, wb_wdata_ex_en_i}))
    else $error("EX/WB register changed while write-back was stalled");

  step_bound: assert property (@(posedge clk) disable iff (!rst_n)
    step_run <= `EX_MULH_STEPS)
    else $error("Multiplier stayed in STEP too long");

endmodule

bind ex_stage ex_stage_checker i_ex_stage_checker
(
  .clk              (clk),
  .rst_n            (rst_n),
  .ex_valid_i       (ex_valid_o),
  .wb_ready_i       (wb_ready_i),
  .mult_en_i        (mult_en_i),
  .mult_op_i        (mult_operator_i),
  .mult_state_i     (i_ex_mult.state_q),
  .wb_rf_we_i       (wb_rf_we_o),
  .wb_rf_waddr_i    (wb_rf_waddr_o),
  .wb_rf_wdata_i    (wb_rf_wdata_o),
  .wb_wdata_ex_en_i (wb_wdata_ex_en_o)
);

`default_nettype wire

/* sim/tb_ex_stage.sv */
/*
  Testbench for the execute stage
  Clock and reset, LFSR stimulus, reference model for write-back data
  and branch decisions, write-back compare process, watchdog
*/

`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage;

  typedef logic [`EX_XLEN-1:0]      word_t;
  typedef logic [`EX_RF_ADDR_W-1:0] addr_t;

  // One expected EX/WB update per instruction that reaches write-back
  typedef struct packed
  {
    logic  we;
    logic  data_req;
    addr_t waddr;
    word_t wdata;
  } wb_entry_t;

  localparam int RESET_CYCLES = 8;
  localparam int N_ALU        = 48;
  localparam int N_BRANCH     = 18;
  localparam int N_MULT       = 32;
  localparam int N_CSR_LOAD   = 8;
  localparam int N_INSTR      = N_ALU + N_BRANCH + N_MULT + 2 * N_CSR_LOAD;
  localparam logic [31:0] LFSR_SEED = 32'hca64efc4;

  logic                clk;
  logic                rst_n;
  logic                alu_en_i;
  ex_pkg::alu_op_e     alu_operator_i;
  word_t               alu_operand_a_i;
  word_t               alu_operand_b_i;
  logic                mult_en_i;
  ex_pkg::mult_op_e    mult_operator_i;
  word_t               mult_operand_a_i;
  word_t               mult_operand_b_i;
  logic                csr_en_i;
  logic                data_req_i;
  logic                rf_we_i;
  addr_t               rf_waddr_i;
  word_t               operand_c_i;
  logic                branch_in_ex_i;
  word_t               csr_rdata_i;
  logic                lsu_ready_ex_i;
  logic                wb_ready_i;
  logic                rf_we_ex_o;
  addr_t               rf_waddr_ex_o;
  word_t               rf_wdata_ex_o;
  logic                branch_decision_o;
  word_t               jump_target_o;
  logic                ex_ready_o;
  logic                ex_valid_o;
  logic                wb_rf_we_o;
  addr_t               wb_rf_waddr_o;
  word_t               wb_rf_wdata_o;
  logic                wb_wdata_ex_en_o;

  logic [31:0]         lfsr_q;
  wb_entry_t           exp_q[$];
  wb_entry_t           entry;

  // Expected EX/WB register contents and the edge conditions seen last
  logic                m_we;
  addr_t               m_waddr;
  word_t               m_wdata;
  logic                m_en;
  logic                valid_seen;
  logic                wb_ready_seen;

  ex_stage i_ex_stage
  (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_en_i          (alu_en_i),
    .alu_operator_i    (alu_operator_i),
    .alu_operand_a_i   (alu_operand_a_i),
    .alu_operand_b_i   (alu_operand_b_i),
    .mult_en_i         (mult_en_i),
    .mult_operator_i   (mult_operator_i),
    .mult_operand_a_i  (mult_operand_a_i),
    .mult_operand_b_i  (mult_operand_b_i),
    .csr_en_i          (csr_en_i),
    .data_req_i        (data_req_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .operand_c_i       (operand_c_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .csr_rdata_i       (csr_rdata_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .wb_ready_i        (wb_ready_i),
    .rf_we_ex_o        (rf_we_ex_o),
    .rf_waddr_ex_o     (rf_waddr_ex_o),
    .rf_wdata_ex_o     (rf_wdata_ex_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_wdata_ex_en_o  (wb_wdata_ex_en_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Random source
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic ref_branch(input ex_pkg::alu_op_e op, input word_t a, input word_t b);
    case (op)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return !($signed(a) < $signed(b));
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return !(a < b);
      default:         return 1'b0;
    endcase
  endfunction

  function automatic word_t ref_alu(input ex_pkg::alu_op_e op, input word_t a, input word_t b);
    logic [$clog2(`EX_XLEN)-1:0] sh;
    logic                        flag;
    sh = b[$clog2(`EX_XLEN)-1:0];
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_SLL:  return a << sh;
      ex_pkg::ALU_SRL:  return a >> sh;
      ex_pkg::ALU_SRA:  return $unsigned($signed(a) >>> sh);
      ex_pkg::ALU_SLT:  flag = $signed(a) < $signed(b);
      ex_pkg::ALU_SLTU: flag = a < b;
      default:          flag = ref_branch(op, a, b);
    endcase
    return {{(`EX_XLEN-1){1'b0}}, flag};
  endfunction

  // Full 64-bit product of the extended operands
  function automatic word_t ref_mult(input ex_pkg::mult_op_e op, input word_t a, input word_t b);
    logic [2*`EX_XLEN-1:0] ea;
    logic [2*`EX_XLEN-1:0] eb;
    logic [2*`EX_XLEN-1:0] prod;
    ea   = (op == ex_pkg::MULHU) ? {{`EX_XLEN{1'b0}}, a} : {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    eb   = (op == ex_pkg::MUL || op == ex_pkg::MULH) ?
           {{`EX_XLEN{b[`EX_XLEN-1]}}, b} : {{`EX_XLEN{1'b0}}, b};
    prod = ea * eb;
    return (op == ex_pkg::MUL) ? prod[`EX_XLEN-1:0] : prod[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  function automatic word_t ref_wdata(input logic alu_en, input ex_pkg::alu_op_e aop,
                                      input logic mult_en, input ex_pkg::mult_op_e mop,
                                      input logic csr_en, input word_t csr_data,
                                      input word_t a, input word_t b);
    if (csr_en)
    begin
      return csr_data;
    end
    if (mult_en)
    begin
      return ref_mult(mop, a, b);
    end
    return alu_en ? ref_alu(aop, a, b) : '0;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
    begin
      abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      abort_run($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // Track the EX/WB register across each edge and compare in mid cycle
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      {m_we, m_waddr, m_wdata, m_en} = '0;
      valid_seen    = 1'b0;
      wb_ready_seen = 1'b0;
    end
    else if (valid_seen)
    begin
      if (exp_q.size() == 0)
      begin
        abort_run("Write-back happened with no instruction pending");
      end
      entry = exp_q.pop_front();
      m_we  = entry.we;
      if (entry.we)
      begin
        m_waddr = entry.waddr;
        m_en    = !entry.data_req;
        if (!entry.data_req)
        begin
          m_wdata = entry.wdata;
        end
      end
    end
    else if (wb_ready_seen)
    begin
      m_we = 1'b0;
    end
    check_bit("wb_rf_we_o", wb_rf_we_o, m_we);
    check_addr("wb_rf_waddr_o", wb_rf_waddr_o, m_waddr);
    check_word("wb_rf_wdata_o", wb_rf_wdata_o, m_wdata);
    check_bit("wb_wdata_ex_en_o", wb_wdata_ex_en_o, m_en);
    if (rst_n)
    begin
      if (ex_valid_o && !(wb_ready_i && lsu_ready_ex_i))
      begin
        abort_run("ex_valid_o went high while write-back or the LSU was stalled");
      end
      valid_seen    = ex_valid_o;
      wb_ready_seen = wb_ready_i;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Ready low about one cycle in four
  task automatic drive_stalls();
    wb_ready_i     <= (take_bits(2) != 0);
    lsu_ready_ex_i <= (take_bits(2) != 0);
  endtask

  task automatic idle_cycle();
    alu_en_i       <= 1'b0;
    mult_en_i      <= 1'b0;
    csr_en_i       <= 1'b0;
    data_req_i     <= 1'b0;
    branch_in_ex_i <= 1'b0;
    rf_we_i        <= 1'b0;
    wb_ready_i     <= 1'b1;
    lsu_ready_ex_i <= (take_bits(2) != 0);
    @(posedge clk);
  endtask

  // Present one instruction and hold it until ex_ready_o takes it
  task automatic send(input logic alu_en, input ex_pkg::alu_op_e aop,
                      input logic mult_en, input ex_pkg::mult_op_e mop,
                      input logic csr_en, input logic dreq, input logic branch,
                      input word_t a, input word_t b, input logic we);
    addr_t     waddr;
    word_t     csr_data;
    word_t     target;
    word_t     exp_wdata;
    wb_entry_t e;
    logic      accepted;
    waddr     = addr_t'(take_bits(`EX_RF_ADDR_W));
    csr_data  = take_bits(32);
    target    = take_bits(32);
    exp_wdata = ref_wdata(alu_en, aop, mult_en, mop, csr_en, csr_data, a, b);
    alu_en_i         <= alu_en;
    alu_operator_i   <= aop;
    alu_operand_a_i  <= a;
    alu_operand_b_i  <= b;
    mult_en_i        <= mult_en;
    mult_operator_i  <= mop;
    mult_operand_a_i <= a;
    mult_operand_b_i <= b;
    csr_en_i         <= csr_en;
    data_req_i       <= dreq;
    branch_in_ex_i   <= branch;
    rf_we_i          <= we;
    rf_waddr_i       <= waddr;
    operand_c_i      <= target;
    csr_rdata_i      <= csr_data;
    if (branch)
    begin
      // Write-back held off while the branch must still be taken
      wb_ready_i     <= 1'b0;
      lsu_ready_ex_i <= (take_bits(2) != 0);
    end
    else
    begin
      drive_stalls();
      e.we       = we;
      e.data_req = dreq;
      e.waddr    = waddr;
      e.wdata    = exp_wdata;
      exp_q.push_back(e);
    end
    do
    begin
      @(negedge clk);
      // Forwarding follows the instruction in EX
      check_bit("rf_we_ex_o", rf_we_ex_o, we);
      check_addr("rf_waddr_ex_o", rf_waddr_ex_o, waddr);
      if (ex_valid_o)
      begin
        check_word("rf_wdata_ex_o", rf_wdata_ex_o, exp_wdata);
      end
      if (branch)
      begin
        check_bit("branch_decision_o", branch_decision_o, ref_branch(aop, a, b));
        check_word("jump_target_o", jump_target_o, target);
        check_bit("ex_ready_o", ex_ready_o, 1'b1);
      end
      accepted = ex_ready_o;
      @(posedge clk);
      if (!accepted)
      begin
        drive_stalls();
      end
    end
    while (!accepted);
  endtask

  initial
  begin
    word_t a;
    word_t b;
    lfsr_q           = LFSR_SEED;
    rst_n            <= 1'b0;
    alu_en_i         <= 1'b0;
    alu_operator_i   <= ex_pkg::ALU_ADD;
    alu_operand_a_i  <= '0;
    alu_operand_b_i  <= '0;
    mult_en_i        <= 1'b0;
    mult_operator_i  <= ex_pkg::MUL;
    mult_operand_a_i <= '0;
    mult_operand_b_i <= '0;
    csr_en_i         <= 1'b0;
    data_req_i       <= 1'b0;
    rf_we_i          <= 1'b0;
    rf_waddr_i       <= '0;
    operand_c_i      <= '0;
    branch_in_ex_i   <= 1'b0;
    csr_rdata_i      <= '0;
    lsu_ready_ex_i   <= 1'b1;
    wb_ready_i       <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Every ALU opcode, sometimes with equal operands
    for (int i = 0; i < N_ALU; i++)
    begin
      a = take_bits(32);
      b = (take_bits(2) == 0) ? a : take_bits(32);
      send(1'b1, ex_pkg::alu_op_e'(i % 16), 1'b0, ex_pkg::MUL, 1'b0, 1'b0, 1'b0,
           a, b, (take_bits(3) != 0));
      if (i % 8 == 7)
      begin
        idle_cycle();
      end
    end

    // Branch compares EQ to GEU
    for (int i = 0; i < N_BRANCH; i++)
    begin
      a = take_bits(32);
      b = (take_bits(2) == 0) ? a : take_bits(32);
      send(1'b1, ex_pkg::alu_op_e'(10 + i % 6), 1'b0, ex_pkg::MUL, 1'b0, 1'b0, 1'b1,
           a, b, 1'b0);
    end
    idle_cycle();

    for (int i = 0; i < N_MULT; i++)
    begin
      a = take_bits(32);
      b = take_bits(32);
      send(1'b0, ex_pkg::ALU_ADD, 1'b1, ex_pkg::mult_op_e'(i % 4), 1'b0, 1'b0, 1'b0,
           a, b, 1'b1);
    end

    // A load after each CSR read leaves the CSR data in place
    for (int i = 0; i < N_CSR_LOAD; i++)
    begin
      send(1'b0, ex_pkg::ALU_ADD, 1'b0, ex_pkg::MUL, 1'b1, 1'b0, 1'b0, '0, '0, 1'b1);
      send(1'b0, ex_pkg::ALU_ADD, 1'b0, ex_pkg::MUL, 1'b0, 1'b1, 1'b0, '0, '0, 1'b1);
      idle_cycle();
    end

    idle_cycle();
    idle_cycle();
    @(negedge clk);
    if (exp_q.size() != 0)
    begin
      abort_run($sformatf("%0d instructions were never written back", exp_q.size()));
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // Reset time plus 200 cycles per instruction
  initial
  begin
    repeat (RESET_CYCLES + 200 * N_INSTR) @(posedge clk);
    abort_run("Run hung, the watchdog expired before all instructions were done");
  end

endmodule

`default_nettype wire

/* verilog/ex_alu.sv */
/*
  Combinational RV32 ALU
  Shared adder for add, sub and compares, single right shifter for all
  shifts, bitwise ops and the branch comparison bit
*/

`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_alu
(
  input  logic                 enable_i,
  input  ex_pkg::alu_op_e      operator_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 comparison_result_o
);

  // Adder path
  logic                            subtract;
  logic [`EX_XLEN-1:0]             adder_b;
  logic [`EX_XLEN:0]               adder_sum;
  logic                            is_equal;
  logic                            lt_signed;
  logic                            lt_unsigned;

  // Shifter path
  logic                            shift_left;
  logic                            shift_arith;
  logic [$clog2(`EX_XLEN)-1:0]     shift_amt;
  logic [`EX_XLEN-1:0]             shift_in;
  logic signed [`EX_XLEN:0]        shift_ext;
  logic signed [`EX_XLEN:0]        shift_res;
  logic [`EX_XLEN-1:0]             shift_right_out;
  logic [`EX_XLEN-1:0]             shift_left_out;

  ////////////////////
  // Adder
  ////////////////////

  // Everything but ADD goes through a + ~b + 1
  assign subtract  = (operator_i != ex_pkg::ALU_ADD);
  assign adder_b   = subtract ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b}
                     + {{`EX_XLEN{1'b0}}, subtract};

  // Zero difference means equal
  assign is_equal    = (adder_sum[`EX_XLEN-1:0] == '0);
  // No carry out of a - b means a < b unsigned
  assign lt_unsigned = ~adder_sum[`EX_XLEN];
  // Differing signs decide directly, otherwise sign of the difference
  assign lt_signed   = (operand_a_i[`EX_XLEN-1] != operand_b_i[`EX_XLEN-1]) ?
                       operand_a_i[`EX_XLEN-1] : adder_sum[`EX_XLEN-1];

  ////////////////////
  // Shifter
  ////////////////////

  // Left shift is a right shift of the bit-reversed operand
  assign shift_left  = (operator_i == ex_pkg::ALU_SLL);
  assign shift_arith = (operator_i == ex_pkg::ALU_SRA);
  assign shift_amt   = operand_b_i[$clog2(`EX_XLEN)-1:0];

  always_comb
  begin
    for (int i = 0; i < `EX_XLEN; i++)
    begin
      shift_in[i] = shift_left ? operand_a_i[`EX_XLEN-1-i] : operand_a_i[i];
    end
  end

  // Extra top bit carries the sign only for SRA
  assign shift_ext       = {shift_arith & operand_a_i[`EX_XLEN-1], shift_in};
  assign shift_res       = shift_ext >>> shift_amt;
  assign shift_right_out = shift_res[`EX_XLEN-1:0];

  always_comb
  begin
    for (int i = 0; i < `EX_XLEN; i++)
    begin
      shift_left_out[i] = shift_right_out[`EX_XLEN-1-i];
    end
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb
  begin
    result_o            = '0;
    comparison_result_o = 1'b0;
    // Idle ALU keeps its outputs quiet
    if (enable_i)
    begin
      unique case (operator_i)
        ex_pkg::ALU_ADD,
        ex_pkg::ALU_SUB:  result_o = adder_sum[`EX_XLEN-1:0];
        ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
        ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
        ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
        ex_pkg::ALU_SLL:  result_o = shift_left_out;
        ex_pkg::ALU_SRL,
        ex_pkg::ALU_SRA:  result_o = shift_right_out;
        ex_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
        ex_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
        default:
        begin
          // Branch compares, result mirrors the comparison bit
          unique case (operator_i)
            ex_pkg::ALU_EQ:  comparison_result_o = is_equal;
            ex_pkg::ALU_NE:  comparison_result_o = ~is_equal;
            ex_pkg::ALU_LT:  comparison_result_o = lt_signed;
            ex_pkg::ALU_GE:  comparison_result_o = ~lt_signed;
            ex_pkg::ALU_LTU: comparison_result_o = lt_unsigned;
            default:         comparison_result_o = ~lt_unsigned;
          endcase
          result_o = {{(`EX_XLEN-1){1'b0}}, comparison_result_o};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_mult.sv */
/*
  RV32 multiplier
  MUL low word straight from a single-cycle product
  MULH, MULHSU and MULHU through an FSM that adds one 16x16 partial
  product per cycle into a 64-bit accumulator
*/

`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_mult
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  ex_pkg::mult_op_e     operator_i,
  input  logic [`EX_XLEN-1:0]  op_a_i,
  input  logic [`EX_XLEN-1:0]  op_b_i,
  input  logic                 ex_ready_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 ready_o
);

  // FSM and step counter
  ex_pkg::mult_state_e         state_q;
  ex_pkg::mult_state_e         state_d;
  logic [1:0]                  step_cnt_q;
  logic                        last_step;
  logic                        high_req;

  // Operand copies and accumulator
  logic [`EX_XLEN-1:0]         op_a_q;
  logic [`EX_XLEN-1:0]         op_b_q;
  logic [2*`EX_XLEN-1:0]       acc_q;
  logic [2*`EX_XLEN-1:0]       acc_init;
  logic                        sign_a;
  logic                        sign_b;

  // Partial product datapath
  logic [`EX_XLEN/2-1:0]       part_a;
  logic [`EX_XLEN/2-1:0]       part_b;
  logic [`EX_XLEN-1:0]         part_prod;
  logic [2*`EX_XLEN-1:0]       part_shifted;
  logic [`EX_XLEN-1:0]         mul_low;

  ////////////////////
  // Operand setup
  ////////////////////

  assign high_req  = enable_i && (operator_i != ex_pkg::MUL);
  assign last_step = (step_cnt_q == 2'(`EX_MULH_STEPS - 1));

  // Which operands are taken as signed
  assign sign_a = op_a_i[`EX_XLEN-1] && (operator_i != ex_pkg::MULHU);
  assign sign_b = op_b_i[`EX_XLEN-1] && (operator_i == ex_pkg::MULH);

  // Sign extension to 64 bits folded into a start value
  // a_s * b_s = a_u * b_u - a31 * b_u << 32 - b31 * a_u << 32 (mod 2^64)
  always_comb
  begin
    acc_init = '0;
    if (sign_a)
    begin
      acc_init = acc_init - {op_b_i, {`EX_XLEN{1'b0}}};
    end
    if (sign_b)
    begin
      acc_init = acc_init - {op_a_i, {`EX_XLEN{1'b0}}};
    end
  end

  ////////////////////
  // Partial products
  ////////////////////

  // Counter bit 1 picks the half of a, bit 0 the half of b
  assign part_a    = step_cnt_q[1] ? op_a_q[`EX_XLEN-1:`EX_XLEN/2] : op_a_q[`EX_XLEN/2-1:0];
  assign part_b    = step_cnt_q[0] ? op_b_q[`EX_XLEN-1:`EX_XLEN/2] : op_b_q[`EX_XLEN/2-1:0];
  assign part_prod = part_a * part_b;

  always_comb
  begin
    unique case (step_cnt_q)
      2'd0:    part_shifted = {{`EX_XLEN{1'b0}}, part_prod};
      2'd3:    part_shifted = {part_prod, {`EX_XLEN{1'b0}}};
      // Cross terms land on the middle half word
      default: part_shifted = {{(`EX_XLEN/2){1'b0}}, part_prod, {(`EX_XLEN/2){1'b0}}};
    endcase
  end

  // Low word is the same for signed and unsigned
  assign mul_low = op_a_i * op_b_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      ex_pkg::IDLE: if (high_req) state_d = ex_pkg::STEP;
      ex_pkg::STEP: if (last_step) state_d = ex_pkg::DONE;
      // Stay until the stage takes the product
      ex_pkg::DONE: if (ex_ready_i) state_d = ex_pkg::IDLE;
      default:      state_d = ex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= ex_pkg::IDLE;
      step_cnt_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == ex_pkg::STEP)
      begin
        step_cnt_q <= step_cnt_q + 2'd1;
      end
      else
      begin
        step_cnt_q <= '0;
      end
    end
  end

  // Operands latched on start, accumulator runs during STEP
  always_ff @(posedge clk)
  begin
    if ((state_q == ex_pkg::IDLE) && high_req)
    begin
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
      acc_q  <= acc_init;
    end
    else if (state_q == ex_pkg::STEP)
    begin
      acc_q <= acc_q + part_shifted;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  always_comb
  begin
    unique case (state_q)
      ex_pkg::STEP: ready_o = 1'b0;
      ex_pkg::DONE: ready_o = 1'b1;
      // High-half op drops ready in its first cycle
      default:      ready_o = !high_req;
    endcase
  end

  always_comb
  begin
    if (state_q == ex_pkg::DONE)
    begin
      result_o = acc_q[2*`EX_XLEN-1:`EX_XLEN];
    end
    else if (enable_i && (operator_i == ex_pkg::MUL))
    begin
      result_o = mul_low;
    end
    else
    begin
      result_o = '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_pkg.sv */
/*
  Execute stage type package
  ALU opcode, multiplier opcode and multiplier FSM state enums
*/

`default_nettype none

package ex_pkg;

  ////////////////////
  // ALU opcodes
  ////////////////////

  // Arithmetic, logic, shifts, set-less-than, then the branch compares
  typedef enum logic [3:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // Branch compares drive the comparison bit
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  ////////////////////
  // Multiplier
  ////////////////////

  // MUL gives the low word, the others the high word
  typedef enum logic [1:0]
  {
    MUL,
    MULH,
    MULHSU,
    MULHU
  } mult_op_e;

  // Iterative high-half engine states
  typedef enum logic [1:0]
  {
    IDLE,
    STEP,
    DONE
  } mult_state_e;

endpackage

`default_nettype wire

/* verilog/ex_stage.sv */
/*
  Execute stage top level
  ALU and multiplier instances, write data select, forwarding and
  branch outputs, ready and valid strobes, EX/WB pipeline register
*/

`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage
(
  input  logic                      clk,
  input  logic                      rst_n,

  // ID/EX fields
  input  logic                      alu_en_i,
  input  ex_pkg::alu_op_e           alu_operator_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_b_i,
  input  logic                      mult_en_i,
  input  ex_pkg::mult_op_e          mult_operator_i,
  input  logic [`EX_XLEN-1:0]       mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]       mult_operand_b_i,
  input  logic                      csr_en_i,
  input  logic                      data_req_i,
  input  logic                      rf_we_i,
  input  logic [`EX_RF_ADDR_W-1:0]  rf_waddr_i,
  input  logic [`EX_XLEN-1:0]       operand_c_i,
  input  logic                      branch_in_ex_i,

  // CSR read data and stall inputs
  input  logic [`EX_XLEN-1:0]       csr_rdata_i,
  input  logic                      lsu_ready_ex_i,
  input  logic                      wb_ready_i,

  // Forwarding to decode
  output logic                      rf_we_ex_o,
  output logic [`EX_RF_ADDR_W-1:0]  rf_waddr_ex_o,
  output logic [`EX_XLEN-1:0]       rf_wdata_ex_o,

  // Branch outputs to fetch
  output logic                      branch_decision_o,
  output logic [`EX_XLEN-1:0]       jump_target_o,

  // Handshake
  output logic                      ex_ready_o,
  output logic                      ex_valid_o,

  // EX/WB register
  output logic                      wb_rf_we_o,
  output logic [`EX_RF_ADDR_W-1:0]  wb_rf_waddr_o,
  output logic [`EX_XLEN-1:0]       wb_rf_wdata_o,
  output logic                      wb_wdata_ex_en_o
);

  logic [`EX_XLEN-1:0]  alu_result;
  logic                 alu_cmp_result;
  logic [`EX_XLEN-1:0]  mult_result;
  logic                 mult_ready;
  logic                 instr_en;
  logic                 units_ready;

  ////////////////////
  // Units
  ////////////////////

  ex_alu i_ex_alu
  (
    .enable_i            (alu_en_i),
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  // Stage ready releases the multiplier from DONE
  ex_mult i_ex_mult
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mult_en_i),
    .operator_i (mult_operator_i),
    .op_a_i     (mult_operand_a_i),
    .op_b_i     (mult_operand_b_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ////////////////////
  // Write data and forwarding
  ////////////////////

  // Enables are one-hot, nothing enabled gives zero
  always_comb
  begin
    if (csr_en_i)
    begin
      rf_wdata_ex_o = csr_rdata_i;
    end
    else if (mult_en_i)
    begin
      rf_wdata_ex_o = mult_result;
    end
    else if (alu_en_i)
    begin
      rf_wdata_ex_o = alu_result;
    end
    else
    begin
      rf_wdata_ex_o = '0;
    end
  end

  assign rf_we_ex_o        = rf_we_i;
  assign rf_waddr_ex_o     = rf_waddr_i;
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = operand_c_i;

  ////////////////////
  // Handshake
  ////////////////////

  assign instr_en    = alu_en_i || mult_en_i || csr_en_i || data_req_i;
  assign units_ready = mult_ready && lsu_ready_ex_i && wb_ready_i;

  // Branches resolve here, so they never wait on write-back
  assign ex_ready_o = units_ready || branch_in_ex_i;
  assign ex_valid_o = instr_en && units_ready;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_rf_we_o       <= 1'b0;
      wb_rf_waddr_o    <= '0;
      wb_rf_wdata_o    <= '0;
      wb_wdata_ex_en_o <= 1'b0;
    end
    else if (ex_valid_o)
    begin
      wb_rf_we_o <= rf_we_i;
      if (rf_we_i)
      begin
        wb_rf_waddr_o <= rf_waddr_i;
        // Load data arrives in WB, old data is left in place
        if (!data_req_i)
        begin
          wb_rf_wdata_o    <= rf_wdata_ex_o;
          wb_wdata_ex_en_o <= 1'b1;
        end
        else
        begin
          wb_wdata_ex_en_o <= 1'b0;
        end
      end
    end
    else if (wb_ready_i)
    begin
      // Bubble into WB
      wb_rf_we_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire
